/* rtl/mera_cfg.svh */
`ifndef MERA_CFG_SVH
`define MERA_CFG_SVH

// Processors on the system bus
`define MERA_CPUS 4

// Extra memory cycles before the acknowledge
`define MERA_MEM_WAIT 1

// Words per segment, one segment per processor
`define MERA_SEG_WORDS 256

`endif

/* rtl/mera_pkg.sv */
package mera_pkg;

	// Bit 0 is the most significant bit throughout
	typedef logic [0:15] word_t;
	typedef logic [0:15] addr_t;

	// Address halves: segment in bits 0-7, offset in bits 8-15
	typedef logic [0:7] seg_t;
	typedef logic [0:7] off_t;

	// Master side of the bus, all lines active low
	typedef struct packed {
		logic dr_;
		logic dw_;
		addr_t dad_;
		word_t ddt_;
	} bus_req_t;

	// Memory side of the bus, all lines active low
	typedef struct packed {
		logic ok_;
		word_t rdt_;
	} bus_rsp_t;

	// Released bus, every line pulled up
	localparam bus_req_t BUS_IDLE = '1;

	typedef enum logic [0:3] {
		OP_HLT = 4'h0,
		OP_LW  = 4'h1,
		OP_AW  = 4'h2,
		OP_SW  = 4'h3
	} opcode_t;

	typedef enum logic [2:0] {
		CPU_IDLE,
		CPU_FETCH,
		CPU_DECODE,
		CPU_OPER,
		CPU_NEXT
	} cpu_state_t;

	typedef enum logic [1:0] {
		PNL_IDLE,
		PNL_REQ,
		PNL_CYCLE
	} panel_state_t;

endpackage

/* rtl/control_panel.sv */
`timescale 1ns/1ps

module control_panel (
	input logic __clk,
	input logic rst_n,
	input mera_pkg::word_t kl,
	input mera_pkg::addr_t kl_addr,
	input logic panel_store_,
	input logic panel_fetch_,
	input logic start_,
	input logic zw,
	input mera_pkg::bus_rsp_t rsp,
	output logic zg,
	output mera_pkg::bus_req_t req,
	output mera_pkg::word_t w,
	output logic panel_busy,
	output logic start
);

	import mera_pkg::*;

	panel_state_t state;
	logic cmd;
	logic cmd_store;
	addr_t cmd_addr;
	word_t cmd_data;
	logic start_q;

	// Accepted only when idle, store wins over fetch
	assign cmd = (state == PNL_IDLE) && (!panel_store_ || !panel_fetch_);

	// Falling edge of start_ gives one pulse to all processors
	assign start = ~start_ & start_q;

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			start_q <= 1'b1;
		end else begin
			start_q <= start_;
		end
	end

	always_ff @(posedge __clk) begin
		if (cmd) begin
			cmd_store <= ~panel_store_;
			cmd_addr <= kl_addr;
			cmd_data <= kl;
		end
	end

	// ------------------------------------------------------------------
	// Bus master for store and fetch
	// ------------------------------------------------------------------

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			state <= PNL_IDLE;
			zg <= 1'b0;
			req <= BUS_IDLE;
			panel_busy <= 1'b0;
			w <= '0;
		end else begin
			case (state)
			PNL_IDLE: begin
				if (cmd) begin
					panel_busy <= 1'b1;
					zg <= 1'b1;
					state <= PNL_REQ;
				end
			end
			PNL_REQ: begin
				if (zw) begin
					req.dad_ <= ~cmd_addr;
					if (cmd_store) begin
						req.dw_ <= 1'b0;
						req.ddt_ <= ~cmd_data;
					end else begin
						req.dr_ <= 1'b0;
					end
					state <= PNL_CYCLE;
				end
			end
			PNL_CYCLE: begin
				// Hold the lines until memory answers
				if (!rsp.ok_) begin
					if (!cmd_store) begin
						w <= ~rsp.rdt_;
					end
					req <= BUS_IDLE;
					zg <= 1'b0;
					panel_busy <= 1'b0;
					state <= PNL_IDLE;
				end
			end
			default: state <= PNL_IDLE;
			endcase
		end
	end

	a_req_granted: assert property (@(posedge __clk) disable iff (!rst_n)
		(req != BUS_IDLE) |-> zw);

endmodule

/* rtl/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core #(
	parameter int CPU_NUMBER = 0
) (
	input logic __clk,
	input logic rst_n,
	input logic start,
	input logic zw,
	input mera_pkg::bus_rsp_t rsp,
	output logic zg,
	output mera_pkg::bus_req_t req,
	output logic run,
	output logic awaria_
);

	import mera_pkg::*;

	cpu_state_t state;
	word_t ac;
	word_t ir;
	addr_t ic;
	opcode_t op;
	seg_t seg;
	word_t rd;
	logic bus_idle;
	logic cycle_end;

	assign seg = seg_t'(CPU_NUMBER);
	assign op = opcode_t'(ir[0:3]);
	assign rd = ~rsp.rdt_;
	assign bus_idle = req.dr_ & req.dw_;

	// Only this master is driving when ok_ comes back
	assign cycle_end = !bus_idle && !rsp.ok_;

	// ------------------------------------------------------------------
	// Sequencer
	// ------------------------------------------------------------------

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			state <= CPU_IDLE;
			zg <= 1'b0;
			req <= BUS_IDLE;
			run <= 1'b0;
			awaria_ <= 1'b1;
		end else begin
			case (state)
			CPU_IDLE: begin
				if (start) begin
					run <= 1'b1;
					zg <= 1'b1;
					state <= CPU_FETCH;
				end
			end
			CPU_FETCH: begin
				if (bus_idle) begin
					if (zw) begin
						req.dr_ <= 1'b0;
						req.dad_ <= ~ic;
					end
				end else if (!rsp.ok_) begin
					req <= BUS_IDLE;
					zg <= 1'b0;
					state <= CPU_DECODE;
				end
			end
			CPU_DECODE: begin
				case (op)
				OP_LW, OP_AW, OP_SW: begin
					zg <= 1'b1;
					state <= CPU_OPER;
				end
				OP_HLT: begin
					run <= 1'b0;
					state <= CPU_IDLE;
				end
				default: begin
					// Illegal instruction stops the processor with an alarm
					run <= 1'b0;
					awaria_ <= 1'b0;
					state <= CPU_IDLE;
				end
				endcase
			end
			CPU_OPER: begin
				if (bus_idle) begin
					if (zw) begin
						req.dad_ <= ~{seg, ir[8:15]};
						if (op == OP_SW) begin
							req.dw_ <= 1'b0;
							req.ddt_ <= ~ac;
						end else begin
							req.dr_ <= 1'b0;
						end
					end
				end else if (!rsp.ok_) begin
					req <= BUS_IDLE;
					zg <= 1'b0;
					state <= CPU_NEXT;
				end
			end
			CPU_NEXT: begin
				// zg stays low here for one cycle so the arbiter can pass the bus on
				zg <= 1'b1;
				state <= CPU_FETCH;
			end
			default: state <= CPU_IDLE;
			endcase
		end
	end

	// ------------------------------------------------------------------
	// Accumulator, instruction register and counter
	// ------------------------------------------------------------------

	always_ff @(posedge __clk) begin
		if (state == CPU_IDLE && start) begin
			ac <= '0;
			ic <= {seg, 8'h00};
		end
		if (state == CPU_FETCH && cycle_end) begin
			ir <= rd;
			ic[8:15] <= ic[8:15] + 8'd1;
		end
		// Read operand, add wraps modulo 2^16
		if (state == CPU_OPER && cycle_end && !req.dr_) begin
			if (op == OP_AW) begin
				ac <= ac + rd;
			end else begin
				ac <= rd;
			end
		end
	end

	a_req_granted: assert property (@(posedge __clk) disable iff (!rst_n)
		!bus_idle |-> zw);

	a_one_strobe: assert property (@(posedge __clk) disable iff (!rst_n)
		!(!req.dr_ && !req.dw_));

endmodule

/* rtl/bus_arbiter.sv */
`timescale 1ns/1ps
`include "mera_cfg.svh"

module bus_arbiter (
	input logic __clk,
	input logic rst_n,
	input logic [0:`MERA_CPUS] zg,
	output logic [0:`MERA_CPUS] zw
);

	logic [0:`MERA_CPUS] zw_next;
	logic held;

	// Owner keeps the bus while it still requests
	assign held = |(zw & zg);

	always_comb begin
		zw_next = '0;
		if (held) begin
			zw_next = zw;
		end else begin
			// Walk down so the lowest index ends up granted
			for (int i = `MERA_CPUS; i >= 0; i--) begin
				if (zg[i]) begin
					zw_next = '0;
					zw_next[i] = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			zw <= '0;
		end else begin
			zw <= zw_next;
		end
	end

	a_onehot: assert property (@(posedge __clk) disable iff (!rst_n)
		$onehot0(zw));

endmodule

/* rtl/mem_unit.sv */
`timescale 1ns/1ps
`include "mera_cfg.svh"

module mem_unit (
	input logic __clk,
	input logic rst_n,
	input mera_pkg::bus_req_t req,
	output mera_pkg::bus_rsp_t rsp
);

	import mera_pkg::*;

	localparam int DEPTH = `MERA_CPUS * `MERA_SEG_WORDS;
	localparam int CW = $clog2(`MERA_MEM_WAIT + 2);

	word_t mem [0:DEPTH-1];
	addr_t addr;
	seg_t seg;
	off_t off;
	int idx;
	logic present;
	logic done;
	logic access;
	logic [CW-1:0] cnt;

	assign addr = ~req.dad_;
	assign seg = addr[0:7];
	assign off = addr[8:15];

	// Segments fold onto the processors present
	assign idx = (int'(seg) % `MERA_CPUS) * `MERA_SEG_WORDS + int'(off) % `MERA_SEG_WORDS;

	assign present = ~(req.dr_ & req.dw_);
	assign access = present && !done && (cnt == CW'(`MERA_MEM_WAIT));

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			cnt <= '0;
			done <= 1'b0;
			rsp <= '1;
		end else begin
			rsp <= '1;
			if (!present) begin
				cnt <= '0;
				done <= 1'b0;
			end else if (access) begin
				// One ok_ pulse, then wait for the master to let go
				done <= 1'b1;
				cnt <= '0;
				rsp.ok_ <= 1'b0;
				if (!req.dr_) begin
					rsp.rdt_ <= ~mem[idx];
				end
			end else if (!done) begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge __clk) begin
		if (access && !req.dw_) begin
			mem[idx] <= ~req.ddt_;
		end
	end

	a_ok_in_cycle: assert property (@(posedge __clk) disable iff (!rst_n)
		!rsp.ok_ |-> present);

endmodule

/* rtl/mera_top.sv */
`timescale 1ns/1ps
`include "mera_cfg.svh"

module mera_top (
	input logic __clk,
	input logic rst_n,
	input mera_pkg::word_t kl,
	input mera_pkg::addr_t kl_addr,
	input logic panel_store_,
	input logic panel_fetch_,
	input logic start_,
	output mera_pkg::word_t w,
	output logic panel_busy,
	output logic [0:`MERA_CPUS-1] run,
	output logic [0:`MERA_CPUS-1] awaria_
);

	import mera_pkg::*;

	// Panel on bit 0, processor i on bit i+1
	logic [0:`MERA_CPUS] zg;
	logic [0:`MERA_CPUS] zw;
	logic start;

	bus_req_t pnl_req;
	bus_req_t cpu_req [0:`MERA_CPUS-1];
	bus_req_t req_and [0:`MERA_CPUS];
	bus_req_t bus_req;
	bus_rsp_t bus_rsp;

	// ------------------------------------------------------------------
	// Control panel
	// ------------------------------------------------------------------

	control_panel panel (
		.__clk(__clk),
		.rst_n(rst_n),
		.kl(kl),
		.kl_addr(kl_addr),
		.panel_store_(panel_store_),
		.panel_fetch_(panel_fetch_),
		.start_(start_),
		.zw(zw[0]),
		.rsp(bus_rsp),
		.zg(zg[0]),
		.req(pnl_req),
		.w(w),
		.panel_busy(panel_busy),
		.start(start)
	);

	// ------------------------------------------------------------------
	// Processors and wired-AND bus
	// ------------------------------------------------------------------

	// Idle masters drive all ones, so AND-ing them leaves the active one
	assign req_and[0] = pnl_req;

	generate
		for (genvar i = 0; i < `MERA_CPUS; i++) begin : cpus
			cpu_core #(.CPU_NUMBER(i)) cpu (
				.__clk(__clk),
				.rst_n(rst_n),
				.start(start),
				.zw(zw[i+1]),
				.rsp(bus_rsp),
				.zg(zg[i+1]),
				.req(cpu_req[i]),
				.run(run[i]),
				.awaria_(awaria_[i])
			);

			assign req_and[i+1] = req_and[i] & cpu_req[i];
		end
	endgenerate

	assign bus_req = req_and[`MERA_CPUS];

	bus_arbiter arbiter (
		.__clk(__clk),
		.rst_n(rst_n),
		.zg(zg),
		.zw(zw)
	);

	mem_unit memory (
		.__clk(__clk),
		.rst_n(rst_n),
		.req(bus_req),
		.rsp(bus_rsp)
	);

endmodule

/* dv/tb_checker.sv */
`timescale 1ns/1ps
`include "mera_cfg.svh"

module tb_checker (
	input logic clk,
	input logic rst_n,
	input logic [15:0] kl,
	input logic [15:0] kl_addr,
	input logic panel_store_,
	input logic panel_fetch_,
	input logic start_,
	input logic [15:0] w,
	input logic panel_busy,
	input logic [0:`MERA_CPUS-1] run,
	input logic [0:`MERA_CPUS-1] awaria_,
	output int checks,
	output int errors
);

	import mera_pkg::*;

	localparam int DEPTH = `MERA_CPUS * `MERA_SEG_WORDS;
	localparam logic [0:`MERA_CPUS-1] ALL_RUN = '1;

	// Shadow of the word memory built from observed panel stores
	logic [15:0] shadow [0:DEPTH-1];
	logic [15:0] fetch_addr;
	logic fetch_pending;
	logic busy_q;
	logic start_q;
	logic rst_q;
	logic running;
	logic run_due;
	logic [0:`MERA_CPUS-1] exp_awaria_;

	// Segment folds onto the processors present
	function automatic int fold(input logic [15:0] addr);
		return (int'(addr[15:8]) % `MERA_CPUS) * `MERA_SEG_WORDS + int'(addr[7:0]);
	endfunction

	// Runs one processor's program on the shadow and returns its alarm line
	function automatic logic exec_program(input int cpu);
		logic [7:0] seg;
		logic [7:0] pc;
		logic [15:0] ac;
		logic [15:0] ir;
		logic [15:0] ea;
		logic alarm_;
		logic done;
		int steps;
		seg = cpu[7:0];
		pc = 8'h00;
		ac = 16'h0000;
		alarm_ = 1'b1;
		done = 1'b0;
		steps = 0;
		while (!done) begin
			ir = shadow[fold({seg, pc})];
			pc = pc + 8'd1;
			ea = {seg, ir[7:0]};
			case (ir[15:12])
			OP_LW: ac = shadow[fold(ea)];
			OP_AW: ac = ac + shadow[fold(ea)];
			OP_SW: shadow[fold(ea)] = ac;
			OP_HLT: done = 1'b1;
			default: begin
				alarm_ = 1'b0;
				done = 1'b1;
			end
			endcase
			steps++;
			if (steps >= 4 * `MERA_SEG_WORDS) begin
				done = 1'b1;
			end
		end
		return alarm_;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] act,
			input logic [31:0] exp);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR t=%0t signal %s: expected %h, actual %h", $time, name, exp, act);
		end
	endtask

	// ------------------------------------------------------------------
	// Sampling at the falling edge away from DUT updates and stimulus
	// ------------------------------------------------------------------

	always @(negedge clk) begin
		if (!rst_n) begin
			checks = 0;
			errors = 0;
			fetch_pending = 1'b0;
			busy_q = 1'b0;
			start_q = 1'b1;
			running = 1'b0;
			run_due = 1'b0;
			exp_awaria_ = '1;
		end else begin
			if (!rst_q) begin
				compare_value("w", 32'(w), 32'h0);
				compare_value("panel_busy", 32'(panel_busy), 32'h0);
				compare_value("run", 32'(run), 32'h0);
				compare_value("awaria_", 32'(awaria_), 32'(exp_awaria_));
			end
			if (busy_q && !panel_busy && fetch_pending) begin
				compare_value("w", 32'(w), 32'(shadow[fold(fetch_addr)]));
				fetch_pending = 1'b0;
			end
			// Panel takes a command only while idle and store goes first
			if (!panel_busy && !panel_store_) begin
				shadow[fold(kl_addr)] = kl;
			end else if (!panel_busy && !panel_fetch_) begin
				fetch_addr = kl_addr;
				fetch_pending = 1'b1;
			end
			if (!start_ && start_q) begin
				for (int i = 0; i < `MERA_CPUS; i++) begin
					exp_awaria_[i] = exp_awaria_[i] & exec_program(i);
				end
				running = 1'b1;
				run_due = 1'b1;
			end else if (run_due) begin
				// Every processor starts on the edge after the strobe
				compare_value("run", 32'(run), 32'(ALL_RUN));
				run_due = 1'b0;
			end else if (running && run == '0) begin
				compare_value("awaria_", 32'(awaria_), 32'(exp_awaria_));
				running = 1'b0;
			end
			busy_q = panel_busy;
			start_q = start_;
		end
		rst_q = rst_n;
	end

endmodule

/* dv/tb_top.sv */
`timescale 1ns/1ps
`include "mera_cfg.svh"

module tb_top;

	import mera_pkg::*;

	localparam int N_RW = 8;
	localparam int PROG_LEN = 8;
	localparam int DATA_WORDS = 4;
	// Bus cycles per run count the loads, processor cycles and result fetches
	localparam int RUN_CYCLES = `MERA_CPUS * (3 * PROG_LEN + 2 + 3 * DATA_WORDS);
	localparam int BUS_CYCLES = 2 * N_RW + 3 * RUN_CYCLES;
	localparam int CYCLE_LIMIT = BUS_CYCLES * (1 + `MERA_MEM_WAIT + 3) * `MERA_CPUS + 200;

	logic clk;
	logic rst_n;
	logic [15:0] kl;
	logic [15:0] kl_addr;
	logic panel_store_;
	logic panel_fetch_;
	logic start_;
	logic [15:0] w;
	logic panel_busy;
	logic [0:`MERA_CPUS-1] run;
	logic [0:`MERA_CPUS-1] awaria_;
	logic [31:0] lcg_state;
	logic [31:0] rnd;
	logic [15:0] rw_addr [0:N_RW-1];
	int cycles = 0;
	int checks;
	int errors;
	int tests;
	int failed;
	int err_mark;
	int chk_mark;

	mera_top i_dut (
		.__clk(clk),
		.rst_n(rst_n),
		.kl(kl),
		.kl_addr(kl_addr),
		.panel_store_(panel_store_),
		.panel_fetch_(panel_fetch_),
		.start_(start_),
		.w(w),
		.panel_busy(panel_busy),
		.run(run),
		.awaria_(awaria_)
	);

	tb_checker i_chk (
		.clk(clk),
		.rst_n(rst_n),
		.kl(kl),
		.kl_addr(kl_addr),
		.panel_store_(panel_store_),
		.panel_fetch_(panel_fetch_),
		.start_(start_),
		.w(w),
		.panel_busy(panel_busy),
		.run(run),
		.awaria_(awaria_),
		.checks(checks),
		.errors(errors)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, a bus cycle or program never finished", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// ------------------------------------------------------------------
	// Panel and run tasks start and end 2 ns after a rising edge
	// ------------------------------------------------------------------

	task automatic panel_cmd(input logic store, input logic [15:0] addr,
			input logic [15:0] data);
		kl = data;
		kl_addr = addr;
		panel_store_ = ~store;
		panel_fetch_ = store;
		@(posedge clk);
		#2;
		panel_store_ = 1'b1;
		panel_fetch_ = 1'b1;
		while (panel_busy) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic start_run();
		start_ = 1'b0;
		@(posedge clk);
		#2;
		start_ = 1'b1;
		while (run != '0) begin
			@(posedge clk);
			#2;
		end
	endtask

	// len instructions then HLT; an illegal opcode goes at bad_pos if it is in range
	task automatic load_program(input int cpu, input int len, input int bad_pos);
		logic [7:0] seg;
		logic [3:0] op;
		logic [7:0] off;
		logic [31:0] r;
		seg = cpu[7:0];
		for (int i = 0; i < DATA_WORDS; i++) begin
			r = lcg_next();
			panel_cmd(1'b1, {seg, 8'h80 + i[7:0]}, r[31:16]);
			r = lcg_next();
			panel_cmd(1'b1, {seg, 8'h90 + i[7:0]}, r[31:16]);
		end
		for (int i = 0; i < len; i++) begin
			r = lcg_next();
			case (r[31:30])
			2'd0: op = OP_LW;
			2'd3: op = OP_SW;
			default: op = OP_AW;
			endcase
			// Last one stores so every program leaves a result
			if (i == len - 1) begin
				op = OP_SW;
			end
			off = (op == OP_SW || r[20]) ? 8'h90 : 8'h80;
			off = off + {6'd0, r[17:16]};
			if (i == bad_pos) begin
				op = 4'h4 + {1'b0, r[27:25]};
			end
			panel_cmd(1'b1, {seg, i[7:0]}, {op, 4'h0, off});
		end
		panel_cmd(1'b1, {seg, len[7:0]}, {OP_HLT, 12'h000});
	endtask

	task automatic fetch_results(input int cpu);
		for (int i = 0; i < DATA_WORDS; i++) begin
			panel_cmd(1'b0, {cpu[7:0], 8'h90 + i[7:0]}, 16'h0000);
		end
	endtask

	task automatic close_test(input string name);
		// Lets the checker see the last falling edge of the test
		@(posedge clk);
		#2;
		tests++;
		if (errors != err_mark) begin
			failed++;
		end
		$display("test %0d %s: %0d checks, %0d errors", tests, name,
			checks - chk_mark, errors - err_mark);
		err_mark = errors;
		chk_mark = checks;
	endtask

	initial begin
		rst_n = 1'b0;
		kl = 16'h0000;
		kl_addr = 16'h0000;
		panel_store_ = 1'b1;
		panel_fetch_ = 1'b1;
		start_ = 1'b1;
		lcg_state = 32'he639df98;
		tests = 0;
		failed = 0;
		err_mark = 0;
		chk_mark = 0;
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;
		close_test("reset values");

		for (int i = 0; i < N_RW; i++) begin
			rnd = lcg_next();
			rw_addr[i] = rnd[31:16];
			rnd = lcg_next();
			panel_cmd(1'b1, rw_addr[i], rnd[31:16]);
		end
		for (int i = 0; i < N_RW; i++) begin
			panel_cmd(1'b0, rw_addr[i], 16'h0000);
		end
		close_test("panel store and fetch");

		for (int c = 0; c < `MERA_CPUS; c++) begin
			load_program(c, PROG_LEN / 2, -1);
		end
		start_run();
		for (int c = 0; c < `MERA_CPUS; c++) begin
			fetch_results(c);
		end
		close_test("random programs");

		// Different lengths keep the processors contending to the end
		for (int c = 0; c < `MERA_CPUS; c++) begin
			load_program(c, PROG_LEN - 2 * (`MERA_CPUS - 1 - c), -1);
		end
		start_run();
		for (int c = 0; c < `MERA_CPUS; c++) begin
			fetch_results(c);
		end
		close_test("bus contention");

		for (int c = 0; c < `MERA_CPUS; c++) begin
			load_program(c, PROG_LEN - 3, (c == `MERA_CPUS / 2) ? 2 : -1);
		end
		start_run();
		for (int c = 0; c < `MERA_CPUS; c++) begin
			fetch_results(c);
		end
		close_test("illegal opcode");

		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
		if (errors == 0 && failed == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* list.f */
+incdir+rtl
rtl/mera_pkg.sv
rtl/control_panel.sv
rtl/cpu_core.sv
rtl/bus_arbiter.sv
rtl/mem_unit.sv
rtl/mera_top.sv
dv/tb_checker.sv
dv/tb_top.sv

/* run.sh */
#!/bin/bash
# Build and run with Verilator, then look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f list.f --top-module tb_top -o tb_sim \
	|| { echo "build failed"; exit 1; }
./obj_dir/tb_sim | tee /dev/stderr | grep -qx "NO ERRORS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
